// File: axi_arb_pkg.sv
package axi_arb_pkg;

    // ==================================================
    // Field widths
    // ==================================================
    localparam int ID_W    = 4;
    localparam int PC_W    = 32;
    localparam int ADDR_W  = 64;
    localparam int DATA_W  = 64;

    typedef logic [ID_W-1:0]   id_t;          // Transaction ID where zero means no grant
    typedef logic [PC_W-1:0]   fetch_addr_t;  // Instruction fetch pc
    typedef logic [ADDR_W-1:0] bus_addr_t;    // Shared bus and memory address
    typedef logic [DATA_W-1:0] data_t;        // One read beat

    // ==================================================
    // Arbiter states
    // ==================================================
    // A round either serves one source in single, or both sources in
    // first and second, and always passes through finish before idle
    typedef enum logic [2:0] {
        ARB_IDLE   = 3'd0,   // Waiting for any pending source
        ARB_SINGLE = 3'd1,   // Serving the only pending source
        ARB_FIRST  = 3'd2,   // Serving memory when both were pending
        ARB_SECOND = 3'd3,   // Serving fetch after memory completed
        ARB_FINISH = 3'd4    // One idle cycle before the next round
    } arb_state_e;

    // ==================================================
    // Default source IDs
    // ==================================================
    localparam id_t DEF_FETCH_ID = 4'd1;   // Instruction fetch
    localparam id_t DEF_MEM_ID   = 4'd2;   // Load unit

endpackage

// File: bus_req_if.sv
`timescale 1ns/10ps

// Carries one granted request from the arbiter to the AXI master and the
// completion of that request back the other way
interface bus_req_if;

    import axi_arb_pkg::*;

    // Grant side, driven by the arbiter
    logic      valid;    // A request is granted
    id_t       id;       // Source ID of the granted request
    bus_addr_t addr;     // Address of the granted request

    // Completion side, driven by the master
    logic      done;     // One-cycle completion pulse
    id_t       ret_id;   // ID returned with the read beat
    data_t     rdata;    // Data returned with the read beat

    modport arb (
        output valid,
        output id,
        output addr,
        input  done,
        input  ret_id,
        input  rdata
    );

    modport mst (
        input  valid,
        input  id,
        input  addr,
        output done,
        output ret_id,
        output rdata
    );

endinterface

// File: req_hold.sv
`timescale 1ns/10ps

module req_hold #(
    parameter type               addr_t = axi_arb_pkg::bus_addr_t,
    parameter axi_arb_pkg::id_t  SRC_ID = axi_arb_pkg::DEF_FETCH_ID
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  addr_t                   req_addr,
    input  logic                    done,
    input  axi_arb_pkg::id_t        ret_id,
    input  axi_arb_pkg::data_t      rdata,
    output logic                    pending,
    output axi_arb_pkg::bus_addr_t  hold_addr,
    output logic                    resp_valid,
    output axi_arb_pkg::data_t      resp_data
);

    import axi_arb_pkg::*;

    logic      accept;     // A new strobe is taken
    logic      complete;   // The completion belongs to this source
    bus_addr_t ext_addr;   // Request address widened to the bus

    assign ext_addr = bus_addr_t'(req_addr);          // Zero-extends the 32-bit pc
    assign accept   = req && !pending;                // A repeat while pending is dropped
    assign complete = pending && done && (ret_id == SRC_ID);

    // ==================================================
    // Pending level and response pulse
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= complete;                   // Exactly one cycle per completion
            if (complete) begin
                pending <= 1'b0;
            end else if (accept) begin
                pending <= 1'b1;
            end
        end
    end

    // Address captured on a new request and data on its completion
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_addr <= ext_addr;                    // Held until the response returns
        end
        if (complete) begin
            resp_data <= rdata;
        end
    end

endmodule

// File: read_arbiter.sv
`timescale 1ns/10ps

module read_arbiter #(
    parameter axi_arb_pkg::id_t FETCH_ID = axi_arb_pkg::DEF_FETCH_ID,
    parameter axi_arb_pkg::id_t MEM_ID   = axi_arb_pkg::DEF_MEM_ID
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_pending,
    input  axi_arb_pkg::bus_addr_t  fetch_addr,
    input  logic                    mem_pending,
    input  axi_arb_pkg::bus_addr_t  mem_addr,
    bus_req_if.arb                  bus
);

    import axi_arb_pkg::*;

    arb_state_e state;
    arb_state_e next_state;
    logic       sel_mem;       // Source served in single, latched in idle
    id_t        single_id;     // ID granted in single
    bus_addr_t  single_addr;   // Address granted in single
    logic       single_done;
    logic       first_done;
    logic       second_done;

    assign single_id   = sel_mem ? MEM_ID : FETCH_ID;
    assign single_addr = sel_mem ? mem_addr : fetch_addr;

    // Completion matched against the source granted in each state
    assign single_done = bus.done && (bus.ret_id == single_id);
    assign first_done  = bus.done && (bus.ret_id == MEM_ID);
    assign second_done = bus.done && (bus.ret_id == FETCH_ID);

    // ==================================================
    // State sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            sel_mem <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ARB_IDLE) begin
                sel_mem <= mem_pending;               // Fixes the source for the whole round
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                if (fetch_pending && mem_pending) begin
                    next_state = ARB_FIRST;           // Memory goes first when both arrive
                end else if (fetch_pending || mem_pending) begin
                    next_state = ARB_SINGLE;
                end
            end
            ARB_SINGLE: if (single_done) next_state = ARB_FINISH;
            ARB_FIRST:  if (first_done)  next_state = ARB_SECOND;
            ARB_SECOND: if (second_done) next_state = ARB_FINISH;
            ARB_FINISH: next_state = ARB_IDLE;
            default:    next_state = ARB_IDLE;
        endcase
    end

    // ==================================================
    // Registered grant
    // ==================================================
    // Outputs follow the present state one edge later. Valid drops as
    // soon as the grant completes so the master sees every new grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.valid <= 1'b0;
            bus.id    <= '0;
            bus.addr  <= '0;
        end else begin
            case (state)
                ARB_SINGLE: begin
                    bus.valid <= !single_done;
                    bus.id    <= single_id;
                    bus.addr  <= single_addr;
                end
                ARB_FIRST: begin
                    bus.valid <= !first_done;
                    bus.id    <= MEM_ID;
                    bus.addr  <= mem_addr;
                end
                ARB_SECOND: begin
                    bus.valid <= !second_done;
                    bus.id    <= FETCH_ID;
                    bus.addr  <= fetch_addr;
                end
                default: begin
                    bus.valid <= 1'b0;
                    bus.id    <= '0;                  // ID zero marks no grant
                    bus.addr  <= '0;
                end
            endcase
        end
    end

endmodule

// File: axi_rd_master.sv
`timescale 1ns/10ps

module axi_rd_master (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    arready,
    input  logic                    rvalid,
    input  axi_arb_pkg::id_t        rid,
    input  axi_arb_pkg::data_t      rdata_in,
    bus_req_if.mst                  bus,
    output logic                    arvalid,
    output axi_arb_pkg::id_t        arid,
    output axi_arb_pkg::bus_addr_t  araddr
);

    logic issued;      // An AR was already sent for the current grant
    logic new_grant;   // Grant seen that has no AR yet
    logic ar_fire;     // AR handshake on this edge

    assign new_grant = bus.valid && !issued && !arvalid;
    assign ar_fire   = arvalid && arready;

    // ==================================================
    // AR channel
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            issued  <= 1'b0;
        end else begin
            if (new_grant) begin
                arvalid <= 1'b1;
                issued  <= 1'b1;
            end else if (ar_fire) begin
                arvalid <= 1'b0;                      // Low arready only stretches this
            end
            if (!bus.valid) begin
                issued <= 1'b0;                       // Ready for the next grant
            end
        end
    end

    // Address and ID stay put until the handshake
    always_ff @(posedge clk) begin
        if (new_grant) begin
            arid   <= bus.id;
            araddr <= bus.addr;
        end
    end

    // ==================================================
    // R channel
    // ==================================================
    // Every beat is accepted and is the last one of its read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= rvalid;                       // One cycle per beat
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid) begin
            bus.ret_id <= rid;
            bus.rdata  <= rdata_in;
        end
    end

endmodule

// File: mem_arb_top.sv
`timescale 1ns/10ps

module mem_arb_top #(
    parameter axi_arb_pkg::id_t FETCH_ID = axi_arb_pkg::DEF_FETCH_ID,
    parameter axi_arb_pkg::id_t MEM_ID   = axi_arb_pkg::DEF_MEM_ID
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_req,
    input  axi_arb_pkg::fetch_addr_t    fetch_pc,
    input  logic                        mem_req,
    input  axi_arb_pkg::bus_addr_t      mem_addr,
    input  logic                        arready,
    input  logic                        rvalid,
    input  axi_arb_pkg::id_t            rid,
    input  axi_arb_pkg::data_t          rdata,
    output logic                        fetch_resp_valid,
    output axi_arb_pkg::data_t          fetch_resp_data,
    output logic                        mem_resp_valid,
    output axi_arb_pkg::data_t          mem_resp_data,
    output logic                        arvalid,
    output axi_arb_pkg::id_t            arid,
    output axi_arb_pkg::bus_addr_t      araddr
);

    import axi_arb_pkg::*;

    logic      fetch_pending;
    bus_addr_t fetch_hold_addr;   // Zero-extended pc
    logic      mem_pending;
    bus_addr_t mem_hold_addr;

    bus_req_if bus_if ();

    // ==================================================
    // Input stages
    // ==================================================
    req_hold #(.addr_t(fetch_addr_t), .SRC_ID(FETCH_ID)) fetch_hold_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (fetch_req),
        .req_addr   (fetch_pc),
        .done       (bus_if.done),      // Completion goes to both stages
        .ret_id     (bus_if.ret_id),
        .rdata      (bus_if.rdata),
        .pending    (fetch_pending),
        .hold_addr  (fetch_hold_addr),
        .resp_valid (fetch_resp_valid),
        .resp_data  (fetch_resp_data)
    );

    req_hold #(.addr_t(bus_addr_t), .SRC_ID(MEM_ID)) mem_hold_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (mem_req),
        .req_addr   (mem_addr),
        .done       (bus_if.done),
        .ret_id     (bus_if.ret_id),
        .rdata      (bus_if.rdata),
        .pending    (mem_pending),
        .hold_addr  (mem_hold_addr),
        .resp_valid (mem_resp_valid),
        .resp_data  (mem_resp_data)
    );

    // ==================================================
    // Arbiter and AXI read master
    // ==================================================
    read_arbiter #(.FETCH_ID(FETCH_ID), .MEM_ID(MEM_ID)) read_arbiter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pending (fetch_pending),
        .fetch_addr    (fetch_hold_addr),
        .mem_pending   (mem_pending),
        .mem_addr      (mem_hold_addr),
        .bus           (bus_if.arb)
    );

    axi_rd_master axi_rd_master_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .arready  (arready),
        .rvalid   (rvalid),
        .rid      (rid),
        .rdata_in (rdata),
        .bus      (bus_if.mst),
        .arvalid  (arvalid),
        .arid     (arid),
        .araddr   (araddr)
    );

endmodule

// File: tb_axi_slave.sv
`timescale 1ns/10ps

module tb_axi_slave (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    arvalid,
    input  axi_arb_pkg::id_t        arid,
    input  axi_arb_pkg::bus_addr_t  araddr,
    input  logic [1:0]              stall_pick,    // Random arready stall of 0 to 3 cycles
    input  logic [2:0]              extra_stall,   // Added stall for back-pressure tests
    input  logic [2:0]              lat_pick,      // Random latency minus one
    output logic                    arready,
    output logic                    rvalid,
    output axi_arb_pkg::id_t        rid,
    output axi_arb_pkg::data_t      rdata
);

    import axi_arb_pkg::*;

    id_t       acc_id;      // ID of the accepted read
    bus_addr_t acc_addr;    // Address of the accepted read
    int        stall;
    int        latency;

    // One read at a time
    // All outputs change on the falling edge
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (rst_n && arvalid) begin
                stall   = stall_pick + extra_stall;
                latency = lat_pick + 1;                // 1 to 8 cycles after the AR handshake
                repeat (stall) @(negedge clk);
                arready  = 1'b1;
                acc_id   = arid;
                acc_addr = araddr;
                @(negedge clk);
                arready = 1'b0;
                repeat (latency - 1) @(negedge clk);
                rid    = acc_id;
                rdata  = ~acc_addr;                    // Data is the inverted address
                rvalid = 1'b1;
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

endmodule

// File: tb_mem_arb.sv
`timescale 1ns/10ps

module tb_mem_arb;

    import axi_arb_pkg::*;

    localparam id_t FETCH_ID   = DEF_FETCH_ID;
    localparam id_t MEM_ID     = DEF_MEM_ID;
    localparam int  MAX_CYCLES = 4000;   // About twice the worst-case length of all tests

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    fetch_addr_t fetch_pc;
    logic        mem_req;
    bus_addr_t   mem_addr;
    logic        arready;
    logic        rvalid;
    id_t         rid;
    data_t       rdata;
    logic        fetch_resp_valid;
    data_t       fetch_resp_data;
    logic        mem_resp_valid;
    data_t       mem_resp_data;
    logic        arvalid;
    id_t         arid;
    bus_addr_t   araddr;
    logic [1:0]  stall_pick;
    logic [2:0]  extra_stall;
    logic [2:0]  lat_pick;

    logic [31:0] lfsr;
    int          cycles = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          ar_count = 0;
    int          resp_count = 0;
    int          req_count = 0;
    int          stall_seen = 0;
    logic        fetch_inflight = 1'b0;   // Set on a taken strobe and cleared on its response
    logic        mem_inflight = 1'b0;
    logic        rd_busy = 1'b0;          // AR accepted and R beat not yet returned
    logic        hold_prev = 1'b0;        // AR was stalled on the last edge
    id_t         prev_arid;
    bus_addr_t   prev_araddr;
    bus_addr_t   exp_fetch_q[$];          // Scoreboard of the address in flight per source
    bus_addr_t   exp_mem_q[$];
    id_t         ar_log[$];
    id_t         resp_log[$];

    mem_arb_top #(.FETCH_ID(FETCH_ID), .MEM_ID(MEM_ID)) mem_arb_top_inst (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc), .mem_req(mem_req), .mem_addr(mem_addr),
        .arready(arready), .rvalid(rvalid), .rid(rid), .rdata(rdata),
        .fetch_resp_valid(fetch_resp_valid), .fetch_resp_data(fetch_resp_data),
        .mem_resp_valid(mem_resp_valid), .mem_resp_data(mem_resp_data),
        .arvalid(arvalid), .arid(arid), .araddr(araddr)
    );

    tb_axi_slave slave_inst (
        .clk(clk), .rst_n(rst_n), .arvalid(arvalid), .arid(arid), .araddr(araddr),
        .stall_pick(stall_pick), .extra_stall(extra_stall), .lat_pick(lat_pick),
        .arready(arready), .rvalid(rvalid), .rid(rid), .rdata(rdata)
    );

    always #20 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================
    // Taps 32, 22, 2 and 1 with one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        assert (act === exp) else begin
            err_count++;
            $display("Mismatch at %0t ns: %0s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string what);
        err_count++;
        $display("Error at %0t ns: %0s", $time, what);
    endtask

    task automatic check_outputs_low();
        check_value("arvalid", 0, arvalid);
        check_value("fetch_resp_valid", 0, fetch_resp_valid);
        check_value("mem_resp_valid", 0, mem_resp_valid);
    endtask

    // Called on a falling edge
    // A strobe on a busy source is a dropped repeat
    task automatic send(input logic do_fetch, input fetch_addr_t pc,
                        input logic do_mem, input bus_addr_t addr);
        fetch_req = do_fetch;
        fetch_pc  = pc;
        mem_req   = do_mem;
        mem_addr  = addr;
        if (do_fetch && !fetch_inflight) begin
            exp_fetch_q.push_back({32'h0, pc});
            fetch_inflight = 1'b1;
            req_count++;
        end
        if (do_mem && !mem_inflight) begin
            exp_mem_q.push_back(addr);
            mem_inflight = 1'b1;
            req_count++;
        end
        @(negedge clk);
        fetch_req = 1'b0;
        mem_req   = 1'b0;
    endtask

    task automatic wait_quiet();
        while (fetch_inflight || mem_inflight) @(negedge clk);
        repeat (3) @(negedge clk);                     // Arbiter passes finish back to idle
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("Test %0s: %0d errors", name, err_count - errs_before);
    endtask

    // ==================================================
    // Monitor and assertions
    // ==================================================
    always @(posedge clk) begin
        stall_pick <= 2'(rand_bits(2));
        lat_pick   <= 3'(rand_bits(3));
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_prev) begin                       // AR must hold through a stall
                check_value("arvalid", 1, arvalid);
                check_value("arid", prev_arid, arid);
                check_value("araddr", prev_araddr, araddr);
            end
            if (arvalid && !arready) stall_seen++;
            if (arvalid && arready) begin
                ar_count++;
                ar_log.push_back(arid);
                if (arid == FETCH_ID && exp_fetch_q.size() > 0) begin
                    check_value("araddr", exp_fetch_q[0], araddr);
                end else if (arid == MEM_ID && exp_mem_q.size() > 0) begin
                    check_value("araddr", exp_mem_q[0], araddr);
                end else begin
                    note_failure("AR accepted with no request waiting for its ID");
                end
            end
            if (fetch_resp_valid) begin
                resp_count++;
                resp_log.push_back(FETCH_ID);
                if (exp_fetch_q.size() == 0) note_failure("fetch response without a request");
                else check_value("fetch_resp_data", ~exp_fetch_q.pop_front(), fetch_resp_data);
                fetch_inflight = 1'b0;
            end
            if (mem_resp_valid) begin
                resp_count++;
                resp_log.push_back(MEM_ID);
                if (exp_mem_q.size() == 0) note_failure("memory response without a request");
                else check_value("mem_resp_data", ~exp_mem_q.pop_front(), mem_resp_data);
                mem_inflight = 1'b0;
            end
            rd_busy <= (arvalid && arready) ? 1'b1 : (rvalid ? 1'b0 : rd_busy);
        end
        hold_prev   <= rst_n && arvalid && !arready;
        prev_arid   <= arid;
        prev_araddr <= araddr;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !arvalid && !fetch_resp_valid
                                  && !mem_resp_valid)
        else note_failure("outputs active during reset");

    single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
                                         !(arvalid && rd_busy))
        else note_failure("AR issued while another read is outstanding");

    // ==================================================
    // Tests
    // ==================================================
    initial begin
        int         errs;
        int         base_ar;
        int         base_resp;
        int         base_req;
        int         base_stall;
        logic [1:0] pick;
        lfsr        = 32'd99773;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_req   = 1'b0;
        fetch_pc    = '0;
        mem_req     = 1'b0;
        mem_addr    = '0;
        stall_pick  = '0;
        extra_stall = '0;
        lat_pick    = '0;

        errs = err_count;
        repeat (4) begin
            @(negedge clk);
            check_outputs_low();
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_outputs_low();
        end
        end_test("reset state", errs);

        errs = err_count;
        base_ar = ar_count;
        ar_log.delete();
        send(1'b1, rand_bits(32), 1'b0, '0);
        wait_quiet();
        send(1'b0, '0, 1'b1, {rand_bits(32), rand_bits(32)});
        wait_quiet();
        check_value("AR count", 2, ar_count - base_ar);
        check_value("first arid", FETCH_ID, ar_log[0]);
        check_value("second arid", MEM_ID, ar_log[1]);
        end_test("single requests", errs);

        errs = err_count;
        ar_log.delete();
        resp_log.delete();
        send(1'b1, rand_bits(32), 1'b1, {rand_bits(32), rand_bits(32)});
        wait_quiet();
        check_value("first arid", MEM_ID, ar_log[0]);
        check_value("second arid", FETCH_ID, ar_log[1]);
        check_value("first response source", MEM_ID, resp_log[0]);
        check_value("second response source", FETCH_ID, resp_log[1]);
        end_test("simultaneous requests", errs);

        errs = err_count;
        base_ar = ar_count;
        base_stall = stall_seen;
        extra_stall = 3'd3;                            // Every AR waits at least three cycles
        send(1'b1, rand_bits(32), 1'b0, '0);
        wait_quiet();
        send(1'b1, rand_bits(32), 1'b1, {rand_bits(32), rand_bits(32)});
        wait_quiet();
        extra_stall = 3'd0;
        check_value("AR count", 3, ar_count - base_ar);
        if (stall_seen == base_stall) note_failure("no arready stall was seen");
        end_test("back-pressure", errs);

        errs = err_count;
        base_ar = ar_count;
        base_resp = resp_count;
        send(1'b1, rand_bits(32), 1'b1, {rand_bits(32), rand_bits(32)});
        repeat (2) @(negedge clk);
        send(1'b1, rand_bits(32), 1'b1, {rand_bits(32), rand_bits(32)});
        wait_quiet();
        check_value("AR count", 2, ar_count - base_ar);
        check_value("response count", 2, resp_count - base_resp);
        end_test("dropped repeat", errs);

        errs = err_count;
        base_ar = ar_count;
        base_req = req_count;
        base_resp = resp_count;
        repeat (40) begin
            pick = 2'(rand_bits(2));
            send(pick[0] && !fetch_inflight, rand_bits(32),
                 pick[1] && !mem_inflight, {rand_bits(32), rand_bits(32)});
            repeat (rand_bits(4)) @(negedge clk);
        end
        wait_quiet();
        check_value("response count", req_count - base_req, resp_count - base_resp);
        check_value("AR count", req_count - base_req, ar_count - base_ar);
        end_test("random mix", errs);

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
axi_arb_pkg.sv
bus_req_if.sv
req_hold.sv
read_arbiter.sv
axi_rd_master.sv
mem_arb_top.sv
tb_axi_slave.sv
tb_mem_arb.sv
